// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Fixed by the instruction format
    localparam int XLEN = 32;
    localparam int RIDX = 5;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        AGU_NONE  = 2'd0,
        AGU_LOAD  = 2'd1,
        AGU_STORE = 2'd2
    } agu_op_e;

    // All zero is a bubble
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [RIDX-1:0] rd;
        logic [RIDX-1:0] rt;
        logic [RIDX-1:0] rs;
        logic [4:0]      shamt;
        logic [25:0]     addr_offset;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        alu_op_e         alu_op;
        logic            alu_src_imm;
        agu_op_e         agu_op;
        logic            flg_branch;
        logic            flg_branch_ne;
        logic            flg_jump;
        logic            flg_reg_wr_en;
        logic            flg_mem_wr_en;
        logic            flg_wb_src;
        logic [RIDX-1:0] dst;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] mem_addr;
        logic [XLEN-1:0] store_data;
        logic [RIDX-1:0] dst;
        logic            flg_reg_wr_en;
        logic            flg_mem_wr_en;
        logic            flg_mem_rd;
        logic            flg_wb_src;
        logic            branch_taken;
        logic [XLEN-1:0] branch_target;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: decode/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  logic [mips_pkg::XLEN-1:0] i_instr,
    input  logic [mips_pkg::XLEN-1:0] i_pc,
    input  logic [mips_pkg::XLEN-1:0] i_rs_data,
    input  logic [mips_pkg::XLEN-1:0] i_rt_data,
    output logic [mips_pkg::RIDX-1:0] o_rs_addr,
    output logic [mips_pkg::RIDX-1:0] o_rt_addr,
    output mips_pkg::id_ex_t          o_id_ex
);

    logic [5:0]               opcode;
    logic [5:0]               funct;
    logic [15:0]              imm16;
    logic                     valid;
    mips_pkg::id_ex_t         dec;

    assign opcode    = i_instr[31:26];
    assign funct     = i_instr[5:0];
    assign imm16     = i_instr[15:0];
    assign o_rs_addr = i_instr[25:21];
    assign o_rt_addr = i_instr[20:16];

    always_comb begin
        valid           = 1'b1;
        dec             = '0;
        dec.pc          = i_pc;
        dec.rs          = i_instr[25:21];
        dec.rt          = i_instr[20:16];
        dec.rd          = i_instr[15:11];
        dec.shamt       = i_instr[10:6];
        dec.addr_offset = i_instr[25:0];
        dec.src_a       = i_rs_data;
        dec.src_b       = i_rt_data;
        dec.imm         = {{16{imm16[15]}}, imm16};
        // I-type writes rt
        dec.dst         = i_instr[20:16];

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dec.dst           = i_instr[15:11];
                dec.flg_reg_wr_en = 1'b1;
                case (funct)
                    mips_pkg::FN_ADD: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT: dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: dec.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL: dec.alu_op = mips_pkg::ALU_SRL;
                    default:          valid      = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                dec.alu_op        = mips_pkg::ALU_ADD;
                dec.alu_src_imm   = 1'b1;
                dec.flg_reg_wr_en = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                dec.imm           = {16'h0000, imm16};
                dec.alu_op        = mips_pkg::ALU_AND;
                dec.alu_src_imm   = 1'b1;
                dec.flg_reg_wr_en = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                dec.imm           = {16'h0000, imm16};
                dec.alu_op        = mips_pkg::ALU_OR;
                dec.alu_src_imm   = 1'b1;
                dec.flg_reg_wr_en = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                dec.alu_op        = mips_pkg::ALU_LUI;
                dec.alu_src_imm   = 1'b1;
                dec.flg_reg_wr_en = 1'b1;
            end
            mips_pkg::OP_LW: begin
                dec.alu_op        = mips_pkg::ALU_ADD;
                dec.alu_src_imm   = 1'b1;
                dec.agu_op        = mips_pkg::AGU_LOAD;
                dec.flg_reg_wr_en = 1'b1;
                dec.flg_wb_src    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                dec.alu_op        = mips_pkg::ALU_ADD;
                dec.alu_src_imm   = 1'b1;
                dec.agu_op        = mips_pkg::AGU_STORE;
                dec.flg_mem_wr_en = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                dec.alu_op     = mips_pkg::ALU_SUB;
                dec.flg_branch = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                dec.alu_op        = mips_pkg::ALU_SUB;
                dec.flg_branch    = 1'b1;
                dec.flg_branch_ne = 1'b1;
            end
            mips_pkg::OP_J: begin
                dec.flg_jump = 1'b1;
            end
            default: valid = 1'b0;
        endcase
    end

    // Unsupported encodings leave as a bubble
    assign o_id_ex = valid ? dec : '0;

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic [mips_pkg::RIDX-1:0] i_rs_addr,
    input  logic [mips_pkg::RIDX-1:0] i_rt_addr,
    output logic [mips_pkg::XLEN-1:0] o_rs_data,
    output logic [mips_pkg::XLEN-1:0] o_rt_data,
    input  logic                      i_wr_en,
    input  logic [mips_pkg::RIDX-1:0] i_wr_addr,
    input  logic [mips_pkg::XLEN-1:0] i_wr_data
);

    localparam int NREGS = 2 ** mips_pkg::RIDX;

    // Entry 0 exists only as a hard zero
    logic [mips_pkg::XLEN-1:0] regs [1:NREGS-1];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // No write bypass, reads see the value before the edge
    always_comb begin
        if (i_rs_addr == '0) begin
            o_rs_data = '0;
        end else begin
            o_rs_data = regs[i_rs_addr];
        end
    end

    always_comb begin
        if (i_rt_addr == '0) begin
            o_rt_data = '0;
        end else begin
            o_rt_data = regs[i_rt_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_step,
    input  logic     i_flush,
    input  payload_t i_d,
    output payload_t o_q
);

    payload_t q;

    // Flush wins over step, an all-zero payload is a bubble
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            q <= '0;
        end else if (i_flush) begin
            q <= '0;
        end else if (i_step) begin
            q <= i_d;
        end
    end

    assign o_q = q;

endmodule

`default_nettype wire

// File: execute/exec_unit.sv
`default_nettype none

module exec_unit (
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);

    logic [mips_pkg::XLEN-1:0] op_a;
    logic [mips_pkg::XLEN-1:0] op_b;
    logic [mips_pkg::XLEN-1:0] alu_res;
    logic [mips_pkg::XLEN-1:0] agu_addr;
    logic [mips_pkg::XLEN-1:0] pc_plus4;
    logic [mips_pkg::XLEN-1:0] br_target;
    logic [mips_pkg::XLEN-1:0] j_target;
    logic                      operands_eq;
    logic                      br_taken;

    assign op_a = i_id_ex.src_a;
    assign op_b = i_id_ex.alu_src_imm ? i_id_ex.imm : i_id_ex.src_b;

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_ADD: alu_res = op_a + op_b;
            mips_pkg::ALU_SUB: alu_res = op_a - op_b;
            mips_pkg::ALU_AND: alu_res = op_a & op_b;
            mips_pkg::ALU_OR:  alu_res = op_a | op_b;
            mips_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            mips_pkg::ALU_SLT: begin
                alu_res = {{(mips_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            // Shifts take rt, never the immediate
            mips_pkg::ALU_SLL: alu_res = i_id_ex.src_b << i_id_ex.shamt;
            mips_pkg::ALU_SRL: alu_res = i_id_ex.src_b >> i_id_ex.shamt;
            mips_pkg::ALU_LUI: alu_res = {i_id_ex.imm[15:0], 16'h0000};
            default:           alu_res = '0;
        endcase
    end

    // AGU only drives an address for memory ops
    always_comb begin
        if (i_id_ex.agu_op == mips_pkg::AGU_NONE) begin
            agu_addr = '0;
        end else begin
            agu_addr = i_id_ex.src_a + i_id_ex.imm;
        end
    end

    assign pc_plus4    = i_id_ex.pc + 32'd4;
    assign br_target   = pc_plus4 + {i_id_ex.imm[mips_pkg::XLEN-3:0], 2'b00};
    assign j_target    = {pc_plus4[31:28], i_id_ex.addr_offset, 2'b00};
    assign operands_eq = (i_id_ex.src_a == i_id_ex.src_b);

    always_comb begin
        if (i_id_ex.flg_jump) begin
            br_taken = 1'b1;
        end else if (i_id_ex.flg_branch) begin
            // bne inverts the compare
            br_taken = operands_eq ^ i_id_ex.flg_branch_ne;
        end else begin
            br_taken = 1'b0;
        end
    end

    always_comb begin
        o_ex_mem               = '0;
        o_ex_mem.pc            = i_id_ex.pc;
        o_ex_mem.alu_result    = alu_res;
        o_ex_mem.mem_addr      = agu_addr;
        o_ex_mem.store_data    = i_id_ex.src_b;
        o_ex_mem.dst           = i_id_ex.dst;
        o_ex_mem.flg_reg_wr_en = i_id_ex.flg_reg_wr_en;
        o_ex_mem.flg_mem_wr_en = i_id_ex.flg_mem_wr_en;
        o_ex_mem.flg_mem_rd    = (i_id_ex.agu_op == mips_pkg::AGU_LOAD);
        o_ex_mem.flg_wb_src    = i_id_ex.flg_wb_src;
        o_ex_mem.branch_taken  = br_taken;
        o_ex_mem.branch_target = i_id_ex.flg_jump ? j_target : br_target;
    end

endmodule

`default_nettype wire

// File: source/mips_id_ex_top.sv
`default_nettype none

module mips_id_ex_top (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_step,
    input  logic                      i_stall,
    input  logic                      i_mem_flush,
    input  logic [mips_pkg::XLEN-1:0] i_pc,
    input  logic [mips_pkg::XLEN-1:0] i_instr,
    input  logic                      i_wb_en,
    input  logic [mips_pkg::RIDX-1:0] i_wb_addr,
    input  logic [mips_pkg::XLEN-1:0] i_wb_data,
    output mips_pkg::ex_mem_t         o_ex_mem
);

    logic [mips_pkg::RIDX-1:0] rs_addr;
    logic [mips_pkg::RIDX-1:0] rt_addr;
    logic [mips_pkg::XLEN-1:0] rs_data;
    logic [mips_pkg::XLEN-1:0] rt_data;
    mips_pkg::id_ex_t          id_ex_d;
    mips_pkg::id_ex_t          id_ex_q;
    mips_pkg::ex_mem_t         ex_mem_d;

    instr_decoder u_decoder (
        .i_instr   (i_instr),
        .i_pc      (i_pc),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .o_id_ex   (id_ex_d)
    );

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wr_en   (i_wb_en),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data)
    );

    // Stall turns the decode slot into a bubble
    pipe_reg #(
        .payload_t (mips_pkg::id_ex_t)
    ) u_id_ex (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_step   (i_step),
        .i_flush  (i_stall),
        .i_d      (id_ex_d),
        .o_q      (id_ex_q)
    );

    exec_unit u_exec (
        .i_id_ex  (id_ex_q),
        .o_ex_mem (ex_mem_d)
    );

    pipe_reg #(
        .payload_t (mips_pkg::ex_mem_t)
    ) u_ex_mem (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_step   (i_step),
        .i_flush  (i_mem_flush),
        .i_d      (ex_mem_d),
        .o_q      (o_ex_mem)
    );

endmodule

`default_nettype wire

// File: tb/tb_mips_id_ex.sv
`default_nettype none

module tb_mips_id_ex;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 20;
    // Opcode 6'h3f is unused, so this word decodes to a bubble
    localparam logic [31:0] BUBBLE = 32'hfc00_0000;

    logic              i_clk;
    logic              i_arst_n;
    logic              i_step;
    logic              i_stall;
    logic              i_mem_flush;
    logic [31:0]       i_pc;
    logic [31:0]       i_instr;
    logic              i_wb_en;
    logic [4:0]        i_wb_addr;
    logic [31:0]       i_wb_data;
    mips_pkg::ex_mem_t o_ex_mem;

    logic [31:0]       shadow [0:31];
    logic [31:0]       rng_state;
    logic              wb_en_nx;
    logic [4:0]        wb_addr_nx;
    logic [31:0]       wb_data_nx;
    mips_pkg::ex_mem_t exp_id_ex;
    mips_pkg::ex_mem_t exp_ex_mem;
    mips_pkg::ex_mem_t held;
    int                err_cnt;
    int                chk_cnt;
    string             test_name;

    mips_id_ex_top DUT (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_step      (i_step),
        .i_stall     (i_stall),
        .i_mem_flush (i_mem_flush),
        .i_pc        (i_pc),
        .i_instr     (i_instr),
        .i_wb_en     (i_wb_en),
        .i_wb_addr   (i_wb_addr),
        .i_wb_data   (i_wb_data),
        .o_ex_mem    (o_ex_mem)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected execute result, read from the shadow registers
    function automatic mips_pkg::ex_mem_t ref_model(input logic [31:0] instr,
                                                    input logic [31:0] pc);
        mips_pkg::ex_mem_t r;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       simm;
        logic [31:0]       pc4;
        a = shadow[instr[25:21]];
        b = shadow[instr[20:16]];
        simm = {{16{instr[15]}}, instr[15:0]};
        pc4 = pc + 32'd4;
        r = '0;
        r.pc = pc;
        r.store_data = b;
        r.dst = instr[20:16];
        r.flg_reg_wr_en = 1'b1;
        case (instr[31:26])
            mips_pkg::OP_RTYPE: begin
                r.dst = instr[15:11];
                case (instr[5:0])
                    mips_pkg::FN_ADD: r.alu_result = a + b;
                    mips_pkg::FN_SUB: r.alu_result = a - b;
                    mips_pkg::FN_AND: r.alu_result = a & b;
                    mips_pkg::FN_OR:  r.alu_result = a | b;
                    mips_pkg::FN_XOR: r.alu_result = a ^ b;
                    mips_pkg::FN_SLT: r.alu_result = {31'd0, $signed(a) < $signed(b)};
                    mips_pkg::FN_SLL: r.alu_result = b << instr[10:6];
                    mips_pkg::FN_SRL: r.alu_result = b >> instr[10:6];
                    default:          r = '0;
                endcase
            end
            mips_pkg::OP_ADDI: r.alu_result = a + simm;
            mips_pkg::OP_ANDI: r.alu_result = a & {16'h0000, instr[15:0]};
            mips_pkg::OP_ORI:  r.alu_result = a | {16'h0000, instr[15:0]};
            mips_pkg::OP_LUI:  r.alu_result = {instr[15:0], 16'h0000};
            mips_pkg::OP_LW: begin
                r.mem_addr = a + simm;
                r.flg_mem_rd = 1'b1;
                r.flg_wb_src = 1'b1;
            end
            mips_pkg::OP_SW: begin
                r.mem_addr = a + simm;
                r.flg_reg_wr_en = 1'b0;
                r.flg_mem_wr_en = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                r.flg_reg_wr_en = 1'b0;
                r.branch_taken = (instr[31:26] == mips_pkg::OP_BEQ) ? (a == b) : (a != b);
                r.branch_target = pc4 + {simm[29:0], 2'b00};
            end
            mips_pkg::OP_J: begin
                r.flg_reg_wr_en = 1'b0;
                r.branch_taken = 1'b1;
                r.branch_target = {pc4[31:28], instr[25:0], 2'b00};
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic report_err(input string msg);
        err_cnt++;
        $display("ERR %0d ns %s: %s", $time, test_name, msg);
    endtask

    // Fields that carry no meaning for the instruction are not compared
    task automatic check_out(input mips_pkg::ex_mem_t exp_v);
        mips_pkg::ex_mem_t got;
        logic [4:0]        exp_flags;
        logic [4:0]        got_flags;
        logic              has_target;
        got = o_ex_mem;
        exp_flags = {exp_v.flg_reg_wr_en, exp_v.flg_mem_wr_en, exp_v.flg_mem_rd,
                     exp_v.flg_wb_src, exp_v.branch_taken};
        got_flags = {got.flg_reg_wr_en, got.flg_mem_wr_en, got.flg_mem_rd,
                     got.flg_wb_src, got.branch_taken};
        // Model leaves the target at zero for non-branches
        has_target = exp_v.branch_taken || (exp_v.branch_target != '0);
        chk_cnt++;
        if (got_flags !== exp_flags) begin
            report_err($sformatf("flags %b, expected %b", got_flags, exp_flags));
        end
        if (got.pc !== exp_v.pc) begin
            report_err($sformatf("pc %h, expected %h", got.pc, exp_v.pc));
        end
        if (exp_v.flg_reg_wr_en && (got.dst !== exp_v.dst)) begin
            report_err($sformatf("dst %0d, expected %0d", got.dst, exp_v.dst));
        end
        if (exp_v.flg_reg_wr_en && !exp_v.flg_wb_src && (got.alu_result !== exp_v.alu_result)) begin
            report_err($sformatf("alu_result %h, expected %h", got.alu_result, exp_v.alu_result));
        end
        // Address is zero for anything but loads and stores
        if (got.mem_addr !== exp_v.mem_addr) begin
            report_err($sformatf("mem_addr %h, expected %h", got.mem_addr, exp_v.mem_addr));
        end
        if (exp_v.flg_mem_wr_en && (got.store_data !== exp_v.store_data)) begin
            report_err($sformatf("store_data %h, expected %h", got.store_data, exp_v.store_data));
        end
        if (has_target && (got.branch_target !== exp_v.branch_target)) begin
            report_err($sformatf("target %h, expected %h", got.branch_target, exp_v.branch_target));
        end
    endtask

    // One clock: mirror the edge using the inputs held before it, drive new ones
    task automatic tick(input logic [31:0] instr, input logic [31:0] pc,
                        input logic step, input logic stall, input logic flush);
        @(posedge i_clk);
        if (i_mem_flush) begin
            exp_ex_mem = '0;
        end else if (i_step) begin
            exp_ex_mem = exp_id_ex;
        end
        if (i_stall) begin
            exp_id_ex = '0;
        end else if (i_step) begin
            exp_id_ex = ref_model(i_instr, i_pc);
        end
        if (i_wb_en && (i_wb_addr != 5'd0)) begin
            shadow[i_wb_addr] = i_wb_data;
        end
        i_instr <= instr;
        i_pc <= pc;
        i_step <= step;
        i_stall <= stall;
        i_mem_flush <= flush;
        i_wb_en <= wb_en_nx;
        i_wb_addr <= wb_addr_nx;
        i_wb_data <= wb_data_nx;
        @(negedge i_clk);
        check_out(exp_ex_mem);
    endtask

    task automatic issue(input logic [31:0] instr, input logic [31:0] pc);
        tick(instr, pc, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic drain();
        issue(BUBBLE, 32'h0);
        issue(BUBBLE, 32'h0);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb_en_nx = 1'b1;
        wb_addr_nx = addr;
        wb_data_nx = data;
        tick(BUBBLE, 32'h0, 1'b0, 1'b0, 1'b0);
        wb_en_nx = 1'b0;
    endtask

    task automatic run_rtype();
        test_name = "rtype";
        issue(enc_r(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_ADD), 32'h0000_0100);
        issue(enc_r(5'd4, 5'd5, 5'd6, 5'd0, mips_pkg::FN_SUB), 32'h0000_0104);
        issue(enc_r(5'd7, 5'd8, 5'd9, 5'd0, mips_pkg::FN_AND), 32'h0000_0108);
        issue(enc_r(5'd10, 5'd11, 5'd12, 5'd0, mips_pkg::FN_OR), 32'h0000_010c);
        issue(enc_r(5'd13, 5'd14, 5'd15, 5'd0, mips_pkg::FN_XOR), 32'h0000_0110);
        issue(enc_r(5'd16, 5'd17, 5'd18, 5'd0, mips_pkg::FN_SLT), 32'h0000_0114);
        issue(enc_r(5'd17, 5'd16, 5'd19, 5'd0, mips_pkg::FN_SLT), 32'h0000_0118);
        issue(enc_r(5'd0, 5'd20, 5'd21, 5'd7, mips_pkg::FN_SLL), 32'h0000_011c);
        issue(enc_r(5'd0, 5'd22, 5'd23, 5'd13, mips_pkg::FN_SRL), 32'h0000_0120);
        drain();
    endtask

    task automatic run_imm();
        test_name = "immediate";
        issue(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd4, 16'hfff0), 32'h0000_0200);
        issue(enc_i(mips_pkg::OP_ANDI, 5'd5, 5'd6, 16'h8f0f), 32'h0000_0204);
        issue(enc_i(mips_pkg::OP_ORI, 5'd7, 5'd8, 16'hc3a5), 32'h0000_0208);
        issue(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd9, 16'h1234), 32'h0000_020c);
        drain();
    endtask

    task automatic run_mem();
        test_name = "load_store";
        issue(enc_i(mips_pkg::OP_LW, 5'd3, 5'd9, 16'hfff8), 32'h0000_0300);
        issue(enc_i(mips_pkg::OP_SW, 5'd4, 5'd7, 16'h0040), 32'h0000_0304);
        drain();
    endtask

    task automatic run_branch();
        test_name = "branch_jump";
        // Same value in two different registers
        write_reg(5'd13, shadow[12]);
        issue(enc_i(mips_pkg::OP_BEQ, 5'd12, 5'd13, 16'h0010), 32'h0000_0400);
        issue(enc_i(mips_pkg::OP_BEQ, 5'd12, 5'd14, 16'hfff0), 32'h0000_0404);
        issue(enc_i(mips_pkg::OP_BNE, 5'd12, 5'd13, 16'h0004), 32'h0000_0408);
        issue(enc_i(mips_pkg::OP_BNE, 5'd12, 5'd14, 16'hff80), 32'h0000_040c);
        issue({mips_pkg::OP_J, 26'h123_4567}, 32'ha000_0040);
        drain();
        test_name = "reg_zero";
        write_reg(5'd0, 32'hdead_beef);
        issue(enc_r(5'd0, 5'd0, 5'd11, 5'd0, mips_pkg::FN_OR), 32'h0000_0500);
        issue(enc_i(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'h0002), 32'h0000_0504);
        drain();
    endtask

    task automatic run_stall_flush();
        test_name = "stall";
        tick(enc_r(5'd1, 5'd2, 5'd20, 5'd0, mips_pkg::FN_ADD), 32'h0000_0600, 1'b1, 1'b1, 1'b0);
        issue(enc_r(5'd3, 5'd4, 5'd21, 5'd0, mips_pkg::FN_SUB), 32'h0000_0604);
        drain();
        test_name = "flush";
        issue(enc_i(mips_pkg::OP_LW, 5'd3, 5'd9, 16'h0004), 32'h0000_0700);
        issue(enc_i(mips_pkg::OP_SW, 5'd4, 5'd7, 16'h0008), 32'h0000_0704);
        tick(enc_i(mips_pkg::OP_ADDI, 5'd5, 5'd6, 16'h0001), 32'h0000_0708, 1'b1, 1'b0, 1'b1);
        issue(BUBBLE, 32'h0);
        if ({o_ex_mem.flg_mem_wr_en, o_ex_mem.flg_mem_rd, o_ex_mem.flg_reg_wr_en} !== 3'b000) begin
            report_err("store still visible after i_mem_flush");
        end
        drain();
    endtask

    task automatic run_step_hold();
        test_name = "step_hold";
        issue(enc_r(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_XOR), 32'h0000_0800);
        issue(enc_i(mips_pkg::OP_ADDI, 5'd4, 5'd5, 16'h0123), 32'h0000_0804);
        tick(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd6, 16'hbeef), 32'h0000_0808, 1'b0, 1'b0, 1'b0);
        held = o_ex_mem;
        repeat (3) begin
            tick(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd6, 16'hbeef), 32'h0000_0808, 1'b0, 1'b0, 1'b0);
            if (o_ex_mem !== held) begin
                report_err("o_ex_mem changed while i_step was low");
            end
        end
        issue(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd6, 16'hbeef), 32'h0000_0808);
        drain();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        i_arst_n = 1'b0;
        i_step = 1'b0;
        i_stall = 1'b0;
        i_mem_flush = 1'b0;
        i_pc = 32'h0;
        i_instr = BUBBLE;
        i_wb_en = 1'b0;
        i_wb_addr = 5'd0;
        i_wb_data = 32'h0;
        wb_en_nx = 1'b0;
        wb_addr_nx = 5'd0;
        wb_data_nx = 32'h0;
        exp_id_ex = '0;
        exp_ex_mem = '0;
        err_cnt = 0;
        chk_cnt = 0;
        rng_state = 32'hb802;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'h0;
        end
        repeat (3) @(posedge i_clk);
        i_arst_n <= 1'b1;
        test_name = "preload";
        for (int r = 1; r < 32; r++) begin
            rng_state = xorshift32(rng_state);
            write_reg(5'(r), rng_state);
        end
        run_rtype();
        run_imm();
        run_mem();
        run_branch();
        run_stall_flush();
        run_step_hold();
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/mips_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
source/pipe_reg.sv
execute/exec_unit.sv
source/mips_id_ex_top.sv
tb/tb_mips_id_ex.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f build.log sim.log &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_mips_id_ex \
    -f all.f -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim | tee sim.log

grep -q "^All checks passed$" sim.log && echo "PASS" || {
    echo "FAIL: see build.log and sim.log"
    exit 1
}
